// File: src/mipsPkg.sv
package mipsPkg;

    localparam int wordWidth = 32;
    localparam int imemWords = 256;
    localparam int dmemWords = 256;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] opR    = 6'b000000;
    localparam logic [5:0] opJ    = 6'b000010;
    localparam logic [5:0] opBeq  = 6'b000100;
    localparam logic [5:0] opAddi = 6'b001000;
    localparam logic [5:0] opLw   = 6'b100011;
    localparam logic [5:0] opSw   = 6'b101011;

    // function field for R-type, instr[5:0]
    localparam logic [5:0] fnAdd = 6'b100000;
    localparam logic [5:0] fnSub = 6'b100010;
    localparam logic [5:0] fnAnd = 6'b100100;
    localparam logic [5:0] fnOr  = 6'b100101;
    localparam logic [5:0] fnSlt = 6'b101010;

    // classic MIPS ALU control encoding
    typedef enum logic [3:0] {
        aluAnd = 4'b0000,
        aluOr  = 4'b0001,
        aluAdd = 4'b0010,
        aluSub = 4'b0110,
        aluSlt = 4'b0111
    } aluOpT;

    typedef struct packed {
        logic  regDst;   // write rd instead of rt
        logic  aluSrc;   // immediate as second operand
        logic  memToReg; // write back load data
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  branch;   // beq
        logic  jump;     // j
        aluOpT aluOp;
    } ctrlT;

endpackage

// File: src/fetchUnit.sv
`timescale 1ns/1ns

module fetchUnit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          branch,
    input  logic                          jump,
    input  logic                          zero,
    input  logic [mipsPkg::wordWidth-1:0] offset, // already sign-extended
    input  logic [25:0]                   target,
    output logic [mipsPkg::wordWidth-1:0] pc
);

    logic [mipsPkg::wordWidth-1:0] pcPlus4;
    logic [mipsPkg::wordWidth-1:0] branchTarget;
    logic [mipsPkg::wordWidth-1:0] jumpTarget;
    logic [mipsPkg::wordWidth-1:0] nextPc;
    logic                          takeBranch;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {offset[mipsPkg::wordWidth-3:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], target, 2'b00}; // stays in current 256MB region
    assign takeBranch   = branch & zero;

    always_comb begin
        if (jump) begin
            nextPc = jumpTarget;
        end else if (takeBranch) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// File: src/instrMemory.sv
`timescale 1ns/1ns

module instrMemory (
    input  logic                                  clk,
    input  logic                                  progWrite,
    input  logic [$clog2(mipsPkg::imemWords)-1:0] progAddr, // word index
    input  logic [mipsPkg::wordWidth-1:0]         progData,
    input  logic [mipsPkg::wordWidth-1:0]         addr,     // byte address from pc
    output logic [mipsPkg::wordWidth-1:0]         instr
);

    localparam int idxWidth = $clog2(mipsPkg::imemWords);

    logic [mipsPkg::wordWidth-1:0] mem [mipsPkg::imemWords];

    // empty slots decode as sll $0,$0,0
    initial begin
        for (int i = 0; i < mipsPkg::imemWords; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (progWrite) begin
            mem[progAddr] <= progData;
        end
    end

    assign instr = mem[addr[idxWidth+1:2]]; // drop byte offset

endmodule

// File: src/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
    input  logic [5:0]    opcode,
    input  logic [5:0]    funct,
    output mipsPkg::ctrlT ctrl
);

    mipsPkg::aluOpT rAluOp; // operation picked by funct

    always_comb begin
        case (funct)
            mipsPkg::fnAdd: rAluOp = mipsPkg::aluAdd;
            mipsPkg::fnSub: rAluOp = mipsPkg::aluSub;
            mipsPkg::fnAnd: rAluOp = mipsPkg::aluAnd;
            mipsPkg::fnOr:  rAluOp = mipsPkg::aluOr;
            mipsPkg::fnSlt: rAluOp = mipsPkg::aluSlt;
            default:        rAluOp = mipsPkg::aluAdd;
        endcase
    end

    always_comb begin
        ctrl       = '0; // unknown opcode acts as a no-op
        ctrl.aluOp = mipsPkg::aluAdd;
        case (opcode)
            mipsPkg::opR: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = rAluOp;
            end
            mipsPkg::opAddi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsPkg::opLw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
            end
            mipsPkg::opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            mipsPkg::opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = mipsPkg::aluSub; // zero flag means equal
            end
            mipsPkg::opJ: begin
                ctrl.jump = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: src/registerFile.sv
`timescale 1ns/1ns

module registerFile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          writeEnable,
    input  logic [4:0]                    readReg1,
    input  logic [4:0]                    readReg2,
    input  logic [4:0]                    writeReg,
    input  logic [mipsPkg::wordWidth-1:0] writeData,
    output logic [mipsPkg::wordWidth-1:0] readData1,
    output logic [mipsPkg::wordWidth-1:0] readData2
);

    logic [mipsPkg::wordWidth-1:0] regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeReg != 5'd0) begin // $zero is read-only
            regs[writeReg] <= writeData;
        end
    end

    assign readData1 = regs[readReg1];
    assign readData2 = regs[readReg2];

endmodule

// File: src/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [mipsPkg::wordWidth-1:0] a,
    input  logic [mipsPkg::wordWidth-1:0] b,
    input  mipsPkg::aluOpT                op,
    output logic [mipsPkg::wordWidth-1:0] result,
    output logic                          zero
);

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b); // signed compare for slt

    always_comb begin
        case (op)
            mipsPkg::aluAnd: result = a & b;
            mipsPkg::aluOr:  result = a | b;
            mipsPkg::aluAdd: result = a + b;
            mipsPkg::aluSub: result = a - b;
            mipsPkg::aluSlt: result = {{(mipsPkg::wordWidth-1){1'b0}}, lessThan};
            default:         result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: src/dataMemory.sv
`timescale 1ns/1ns

module dataMemory (
    input logic clk,
    dataBus.mem bus
);

    localparam int idxWidth = $clog2(mipsPkg::dmemWords);

    logic [mipsPkg::wordWidth-1:0] mem [mipsPkg::dmemWords];
    logic [idxWidth-1:0]           wordIdx;

    assign wordIdx = bus.addr[idxWidth+1:2]; // word aligned, upper bits wrap

    always_ff @(posedge clk) begin
        if (bus.write) begin
            mem[wordIdx] <= bus.wdata;
        end
    end

    // quiet bus when nothing is loading
    assign bus.rdata = bus.read ? mem[wordIdx] : '0;

endmodule

// File: src/mipsCpu.sv
`timescale 1ns/1ns

interface dataBus;
    logic                          read;
    logic                          write;
    logic [mipsPkg::wordWidth-1:0] addr;
    logic [mipsPkg::wordWidth-1:0] wdata;
    logic [mipsPkg::wordWidth-1:0] rdata;

    modport core (output read, write, addr, wdata, input rdata);
    modport mem  (input read, write, addr, wdata, output rdata);
endinterface

module mipsCpu (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          progWrite,
    input  logic [7:0]                    progAddr,
    input  logic [mipsPkg::wordWidth-1:0] progData,
    output logic [mipsPkg::wordWidth-1:0] pc,
    output logic                          storeValid,
    output logic [mipsPkg::wordWidth-1:0] storeAddr,
    output logic [mipsPkg::wordWidth-1:0] storeData
);

    logic [mipsPkg::wordWidth-1:0] instr;
    logic [mipsPkg::wordWidth-1:0] signImm;
    logic [mipsPkg::wordWidth-1:0] readData1;
    logic [mipsPkg::wordWidth-1:0] readData2;
    logic [mipsPkg::wordWidth-1:0] aluB;
    logic [mipsPkg::wordWidth-1:0] aluResult;
    logic [mipsPkg::wordWidth-1:0] writeBack;
    logic [4:0]                    destReg;
    logic                          zero;
    mipsPkg::ctrlT                 ctrl;

    dataBus bus ();

    fetchUnit uFetch (
        .clk    (clk),
        .reset  (reset),
        .branch (ctrl.branch),
        .jump   (ctrl.jump),
        .zero   (zero),
        .offset (signImm),
        .target (instr[25:0]),
        .pc     (pc)
    );

    instrMemory uImem (
        .clk       (clk),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .addr      (pc),
        .instr     (instr)
    );

    controlUnit uCtrl (
        .opcode (instr[31:26]),
        .funct  (instr[5:0]),
        .ctrl   (ctrl)
    );

    assign signImm   = {{16{instr[15]}}, instr[15:0]};
    assign destReg   = ctrl.regDst ? instr[15:11] : instr[20:16]; // rd for R-type
    assign aluB      = ctrl.aluSrc ? signImm : readData2;
    assign writeBack = ctrl.memToReg ? bus.rdata : aluResult;

    registerFile uRegs (
        .clk         (clk),
        .reset       (reset),
        .writeEnable (ctrl.regWrite & ~reset), // no writeback while held in reset
        .readReg1    (instr[25:21]),
        .readReg2    (instr[20:16]),
        .writeReg    (destReg),
        .writeData   (writeBack),
        .readData1   (readData1),
        .readData2   (readData2)
    );

    alu uAlu (
        .a      (readData1),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (zero)
    );

    assign bus.read  = ctrl.memRead;
    assign bus.write = ctrl.memWrite & ~reset; // block stores during program load
    assign bus.addr  = aluResult;
    assign bus.wdata = readData2;

    dataMemory uDmem (
        .clk (clk),
        .bus (bus)
    );

    // store observation taps the bus directly
    assign storeValid = bus.write;
    assign storeAddr  = bus.addr;
    assign storeData  = bus.wdata;

endmodule

// File: tb/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;

    localparam int resetCycles    = 16;
    localparam int numTests       = 6;
    localparam int progWordsTotal = 43; // words over all six programs
    localparam int timeoutNs      = (numTests * (resetCycles + 2) + progWordsTotal) * 20 + 1000;

    logic        clk;
    logic        reset;
    logic        progWrite;
    logic [7:0]  progAddr;
    logic [31:0] progData;
    logic [31:0] pc;
    logic        storeValid;
    logic [31:0] storeAddr;
    logic [31:0] storeData;

    logic [31:0] lfsrState;
    logic [31:0] prog [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] obsAddr [$];
    logic [31:0] obsData [$];

    mipsCpu DUT (
        .clk        (clk),
        .reset      (reset),
        .progWrite  (progWrite),
        .progAddr   (progAddr),
        .progData   (progData),
        .pc         (pc),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    always #10 clk = ~clk;

    // stores sampled mid-cycle where the bus is settled
    always @(negedge clk) begin
        if (storeValid) begin
            obsAddr.push_back(storeAddr);
            obsData.push_back(storeData);
        end
    end

    initial begin
        #(timeoutNs);
        $display("timeout: the processor did not reach the end of a program in time");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
        return {mipsPkg::opR, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs, rt,
                                         input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encJ(input logic [25:0] target);
        return {mipsPkg::opJ, target};
    endfunction

    function automatic logic [31:0] signExtend(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // halt word jumps to itself, then load under reset and run until pc sits on it
    task automatic runProgram();
        int          loadCycles;
        logic [31:0] haltPc;
        emit(encJ(26'(prog.size())));
        haltPc     = 32'(4 * (prog.size() - 1));
        loadCycles = (prog.size() > resetCycles) ? prog.size() : resetCycles;
        obsAddr.delete();
        obsData.delete();
        @(posedge clk);
        #2;
        reset = 1'b1;
        for (int i = 0; i < loadCycles; i++) begin
            progWrite = (i < prog.size());
            progAddr  = 8'(i);
            progData  = (i < prog.size()) ? prog[i] : '0;
            @(posedge clk);
            #2;
        end
        checkValue("pc", pc, '0);
        checkValue("storeValid", 32'(storeValid), '0);
        progWrite = 1'b0;
        reset     = 1'b0;
        while (pc != haltPc) begin
            @(negedge clk);
        end
        checkValue("storeCount", obsAddr.size(), expAddr.size());
        foreach (expAddr[i]) begin
            checkValue($sformatf("storeAddr[%0d]", i), obsAddr[i], expAddr[i]);
            checkValue($sformatf("storeData[%0d]", i), obsData[i], expData[i]);
        end
        prog.delete();
        expAddr.delete();
        expData.delete();
    endtask

    task automatic arithmeticOps();
        logic [15:0] a;
        logic [15:0] b;
        logic [31:0] x;
        logic [31:0] y;
        logic        lessThan;
        a = randomBits(16);
        b = randomBits(16);
        x = signExtend(a);
        y = signExtend(b);
        emit(encI(mipsPkg::opAddi, 5'd0, 5'd1, a));
        emit(encI(mipsPkg::opAddi, 5'd0, 5'd2, b));
        emit(encR(5'd1, 5'd2, 5'd3, mipsPkg::fnAdd));
        emit(encI(mipsPkg::opSw, 5'd0, 5'd3, 16'h0040));
        emit(encR(5'd1, 5'd2, 5'd3, mipsPkg::fnSub));
        emit(encI(mipsPkg::opSw, 5'd0, 5'd3, 16'h0044));
        emit(encR(5'd1, 5'd2, 5'd3, mipsPkg::fnAnd));
        emit(encI(mipsPkg::opSw, 5'd0, 5'd3, 16'h0048));
        emit(encR(5'd1, 5'd2, 5'd3, mipsPkg::fnOr));
        emit(encI(mipsPkg::opSw, 5'd0, 5'd3, 16'h004c));
        emit(encR(5'd1, 5'd2, 5'd3, mipsPkg::fnSlt));
        emit(encI(mipsPkg::opSw, 5'd0, 5'd3, 16'h0050));
        // negative one is lower, same signs compare by magnitude
        lessThan = (a[15] != b[15]) ? a[15] : (a < b);
        expectStore(32'h40, x + y);
        expectStore(32'h44, x - y);
        expectStore(32'h48, x & y);
        expectStore(32'h4c, x | y);
        expectStore(32'h50, 32'(lessThan));
        runProgram();
    endtask

    task automatic signExtension();
        emit(encI(mipsPkg::opAddi, 5'd0, 5'd1, 16'h0100));
        emit(encI(mipsPkg::opAddi, 5'd1, 5'd2, 16'hfffb)); // 0x100 - 5
        emit(encI(mipsPkg::opSw, 5'd1, 5'd2, 16'hfff8));
        emit(encI(mipsPkg::opAddi, 5'd0, 5'd3, 16'hffff));
        emit(encI(mipsPkg::opSw, 5'd1, 5'd3, 16'hfffc));
        expectStore(32'h0000_00f8, 32'h0000_00fb);
        expectStore(32'h0000_00fc, 32'hffff_ffff);
        runProgram();
    endtask

    task automatic memoryRoundTrip();
        logic [15:0] v;
        v = randomBits(16);
        emit(encI(mipsPkg::opAddi, 5'd0, 5'd1, v));
        emit(encI(mipsPkg::opSw, 5'd0, 5'd1, 16'h0080));
        emit(encI(mipsPkg::opLw, 5'd0, 5'd2, 16'h0080));
        emit(encI(mipsPkg::opSw, 5'd0, 5'd2, 16'h0084)); // data came through r2
        expectStore(32'h80, signExtend(v));
        expectStore(32'h84, signExtend(v));
        runProgram();
    endtask

    task automatic branchFlow();
        emit(encI(mipsPkg::opAddi, 5'd0, 5'd1, 16'd7));
        emit(encI(mipsPkg::opAddi, 5'd0, 5'd2, 16'd7));
        emit(encI(mipsPkg::opAddi, 5'd0, 5'd3, 16'd9));
        emit(encI(mipsPkg::opBeq, 5'd1, 5'd2, 16'd1)); // taken
        emit(encI(mipsPkg::opSw, 5'd0, 5'd1, 16'h0090));
        emit(encI(mipsPkg::opBeq, 5'd1, 5'd3, 16'd1)); // falls through
        emit(encI(mipsPkg::opSw, 5'd0, 5'd3, 16'h0094));
        emit(encI(mipsPkg::opSw, 5'd0, 5'd2, 16'h0098));
        expectStore(32'h94, 32'd9);
        expectStore(32'h98, 32'd7);
        runProgram();
    endtask

    task automatic jumpFlow();
        emit(encI(mipsPkg::opAddi, 5'd0, 5'd1, 16'h0033));
        emit(encJ(26'd4));
        emit(encI(mipsPkg::opSw, 5'd0, 5'd1, 16'h00a0));
        emit(encI(mipsPkg::opSw, 5'd0, 5'd1, 16'h00a4));
        emit(encI(mipsPkg::opSw, 5'd0, 5'd1, 16'h00a8)); // jump target, word 4
        expectStore(32'ha8, 32'h33);
        runProgram();
    endtask

    task automatic registerZero();
        emit(encI(mipsPkg::opSw, 5'd0, 5'd0, 16'h00b4)); // sits at pc 0 while reset holds
        emit(encI(mipsPkg::opAddi, 5'd0, 5'd0, 16'h0055));
        emit(encI(mipsPkg::opSw, 5'd0, 5'd0, 16'h00b0));
        expectStore(32'hb4, 32'd0);
        expectStore(32'hb0, 32'd0);
        runProgram();
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        lfsrState = 32'h60a6_1e06;
        arithmeticOps();
        signExtension();
        memoryRoundTrip();
        branchFlow();
        jumpFlow();
        registerZero();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: tb.f
src/mipsPkg.sv
src/fetchUnit.sv
src/instrMemory.sv
src/controlUnit.sv
src/registerFile.sv
src/alu.sv
src/dataMemory.sv
src/mipsCpu.sv
tb/cpuTb.sv

// File: Makefile
TOP := cpuTb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -f tb.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "all tests passed"

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
